// File: Makefile
sim:
	verilator --binary --timing --assert --top-module datapathTb -f compile.f
	./obj_dir/VdatapathTb

clean:
	rm -rf obj_dir

.PHONY: sim clean

// File: alu.sv
`timescale 1ns/1ps

module alu (
	input  logic [dpPkg::ctlWidth-1:0]     aluCtl,
	input  logic [dpPkg::wordWidth-1:0]    opA,
	input  logic [dpPkg::wordWidth-1:0]    opB,
	output logic [dpPkg::wordWidth-1:0]    result,
	output logic                           carry,
	output logic                           low,
	output logic                           overflow,
	output logic                           negative,
	output logic                           zero
);

	localparam int msb = dpPkg::wordWidth - 1;

	logic [dpPkg::wordWidth:0] sum;   // extra bit is carry out
	logic [dpPkg::wordWidth:0] diff;  // extra bit is borrow
	logic [4:0] shAmt;
	logic shRight;
	logic [4:0] shMag;
	logic [dpPkg::wordWidth-1:0] shlRes;
	logic [dpPkg::wordWidth-1:0] lsrRes;
	logic [dpPkg::wordWidth-1:0] asrRes;

	assign sum = {1'b0, opA} + {1'b0, opB};
	assign diff = {1'b0, opA} - {1'b0, opB};

	// shift amount is a signed 5-bit value, negative means right
	assign shAmt = opB[4:0];
	assign shRight = shAmt[4];
	assign shMag = shRight ? -shAmt : shAmt; // -16 gives 16, clears the word

	assign shlRes = opA << shMag;
	assign lsrRes = opA >> shMag;
	assign asrRes = $signed(opA) >>> shMag;

	always_comb begin
		result = opB;
		carry = 1'b0;
		overflow = 1'b0;
		case (aluCtl)
			dpPkg::ctlAnd: result = opA & opB;
			dpPkg::ctlOr:  result = opA | opB;
			dpPkg::ctlXor: result = opA ^ opB;
			dpPkg::ctlAdd, dpPkg::ctlAddu: begin
				result = sum[msb:0];
				carry = sum[dpPkg::wordWidth];
				overflow = (opA[msb] == opB[msb]) && (sum[msb] != opA[msb]);
			end
			dpPkg::ctlSub, dpPkg::ctlCmp: begin
				// cmp needs the difference only for Z
				result = diff[msb:0];
				carry = diff[dpPkg::wordWidth];
				overflow = (opA[msb] != opB[msb]) && (diff[msb] != opA[msb]);
			end
			dpPkg::ctlMov: result = opB;
			dpPkg::ctlLsh: result = shRight ? lsrRes : shlRes;
			dpPkg::ctlAshu: result = shRight ? asrRes : shlRes; // sign fill on right
			default: result = opB;
		endcase
	end

	// compare outcomes, only kept for cmp by the flag mask
	assign low = opA < opB;
	assign negative = $signed(opA) < $signed(opB);
	assign zero = (result == '0);

endmodule

// File: compile.f
dpPkg.sv
isaPkg.sv
instDecode.sv
regFile.sv
alu.sv
writeback.sv
cr16Datapath.sv
tbClock.sv
datapath_chk.sv
datapathTb.sv

// File: cr16Datapath.sv
`timescale 1ns/1ps

module cr16Datapath (
	input  logic                              clk,
	input  logic                              rst,
	input  logic                              instValid,
	input  logic [dpPkg::wordWidth-1:0]       instWord,
	output logic                              resultValid,
	output logic [dpPkg::regAddrWidth-1:0]    resultAddr,
	output logic [dpPkg::wordWidth-1:0]       resultData,
	output logic [dpPkg::flagWidth-1:0]       flags
);

	logic [dpPkg::regAddrWidth-1:0] rdestAddr;
	logic [dpPkg::regAddrWidth-1:0] rsrcAddr;
	logic [dpPkg::ctlWidth-1:0] aluCtl;
	logic [dpPkg::wordWidth-1:0] immOperand;
	logic useImm;
	logic regWrite;
	logic [dpPkg::flagWidth-1:0] flagMask;
	logic [dpPkg::wordWidth-1:0] readData1;
	logic [dpPkg::wordWidth-1:0] readData2;
	logic [dpPkg::wordWidth-1:0] opB;
	logic [dpPkg::wordWidth-1:0] aluResult;
	logic carry;
	logic low;
	logic overflow;
	logic negative;
	logic zero;
	logic writeEn;
	logic [dpPkg::regAddrWidth-1:0] writeAddr;
	logic [dpPkg::wordWidth-1:0] writeData;

	instDecode uDecode (
		.instWord   (instWord),
		.instValid  (instValid),
		.rdestAddr  (rdestAddr),
		.rsrcAddr   (rsrcAddr),
		.aluCtl     (aluCtl),
		.immOperand (immOperand),
		.useImm     (useImm),
		.regWrite   (regWrite),
		.flagMask   (flagMask)
	);

	// port 1 always reads rdest, it is operand A
	regFile uRegFile (
		.clk       (clk),
		.rst       (rst),
		.writeEn   (writeEn),
		.writeAddr (writeAddr),
		.writeData (writeData),
		.readAddr1 (rdestAddr),
		.readAddr2 (rsrcAddr),
		.readData1 (readData1),
		.readData2 (readData2)
	);

	assign opB = useImm ? immOperand : readData2;

	alu uAlu (
		.aluCtl   (aluCtl),
		.opA      (readData1),
		.opB      (opB),
		.result   (aluResult),
		.carry    (carry),
		.low      (low),
		.overflow (overflow),
		.negative (negative),
		.zero     (zero)
	);

	writeback uWriteback (
		.clk         (clk),
		.rst         (rst),
		.regWrite    (regWrite),
		.rdestAddr   (rdestAddr),
		.flagMask    (flagMask),
		.result      (aluResult),
		.carry       (carry),
		.low         (low),
		.overflow    (overflow),
		.negative    (negative),
		.zero        (zero),
		.writeEn     (writeEn),
		.writeAddr   (writeAddr),
		.writeData   (writeData),
		.resultValid (resultValid),
		.resultAddr  (resultAddr),
		.resultData  (resultData),
		.flags       (flags)
	);

endmodule

// File: datapathTb.sv
`timescale 1ns/1ps

module datapathTb;

	typedef enum {fAnd, fOr, fXor, fAdd, fSub, fCmp, fMov, fLsh, fAshu, fBad} fn_e;

	localparam int randCount = 60;  // each of the four random phases
	localparam int fixedCount = 105;
	localparam int maxCycles = (4 * randCount + fixedCount) * 2 + 16 + 50;

	logic clk;
	logic rst;
	logic instValid;
	logic [15:0] instWord;
	logic resultValid;
	logic [3:0] resultAddr;
	logic [15:0] resultData;
	logic [4:0] flags;

	logic [31:0] lfsr = 32'hd3ef_c595;
	logic [15:0] mRegs [16];
	logic [4:0] mFlags;
	logic expValid;
	logic [3:0] expAddr;
	logic [15:0] expData;
	int cycles = 0;

	logic [3:0] logicExt [4] = '{isaPkg::extAnd, isaPkg::extOr, isaPkg::extXor, isaPkg::extMov};
	logic [3:0] logicOp [4] = '{isaPkg::opAndi, isaPkg::opOri, isaPkg::opXori, isaPkg::opMovi};
	logic [3:0] arithExt [4] = '{isaPkg::extAdd, isaPkg::extAddu, isaPkg::extSub, isaPkg::extAdd};
	logic [3:0] arithOp [4] = '{isaPkg::opAddi, isaPkg::opAddui, isaPkg::opSubi, isaPkg::opAddui};
	logic [3:0] badOp [8] = '{4'h4, 4'h7, 4'ha, 4'hc, 4'he, 4'h4, 4'h7, 4'he};

	tbClock uClock (.clk(clk));

	cr16Datapath DUT (
		.clk         (clk),
		.rst         (rst),
		.instValid   (instValid),
		.instWord    (instWord),
		.resultValid (resultValid),
		.resultAddr  (resultAddr),
		.resultData  (resultData),
		.flags       (flags)
	);

	// fibonacci lfsr with taps 32 22 2 1 stepped once per bit
	function automatic logic [15:0] takeBits(input int n);
		logic [15:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
			v = {v[14:0], lfsr[0]};
		end
		return v;
	endfunction

	// random register form or immediate form of one operation
	function automatic logic [15:0] pickForm(input logic [3:0] ext, input logic [3:0] immOp);
		logic [3:0] rd;
		rd = 4'(takeBits(4));
		if (takeBits(1) != 16'h0)
			return {isaPkg::opRegGroup, rd, ext, 4'(takeBits(4))};
		return {immOp, rd, 8'(takeBits(8))};
	endfunction

	task automatic checkEq(input logic [15:0] got, input logic [15:0] exp, input string what);
		if (got !== exp) begin
			$display("mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
			$display("Test failures found");
			$fatal(1, "value check failed");
		end
	endtask

	// reference model for the accepting edge
	task automatic predict(input logic [15:0] w, input logic v);
		logic [3:0] op;
		logic [3:0] rd;
		logic [15:0] a;
		logic [15:0] b;
		logic [15:0] r;
		logic [4:0] upd;
		logic [4:0] cand;
		fn_e fn;
		int sh;
		int sa;
		op = w[15:12];
		rd = w[11:8];
		a = mRegs[rd];
		b = mRegs[w[3:0]];
		r = '0;
		cand = '0;
		upd = '0;
		upd[dpPkg::flagZ] = 1'b1;
		if (op == isaPkg::opRegGroup) begin
			case (w[7:4])
				isaPkg::extAnd: fn = fAnd;
				isaPkg::extOr: fn = fOr;
				isaPkg::extXor: fn = fXor;
				isaPkg::extAdd, isaPkg::extAddu: fn = fAdd;
				isaPkg::extSub: fn = fSub;
				isaPkg::extCmp: fn = fCmp;
				isaPkg::extMov: fn = fMov;
				default: fn = fBad;
			endcase
		end else if (op == isaPkg::opShiftGroup) begin
			fn = (w[7:4] == isaPkg::extLsh) ? fLsh : ((w[7:4] == isaPkg::extAshu) ? fAshu : fBad);
		end else begin
			b = {8'h00, w[7:0]}; // logic and movi zero-extend
			case (op)
				isaPkg::opAndi: fn = fAnd;
				isaPkg::opOri: fn = fOr;
				isaPkg::opXori: fn = fXor;
				isaPkg::opMovi, isaPkg::opLui: fn = fMov;
				isaPkg::opAddi, isaPkg::opAddui: fn = fAdd;
				isaPkg::opSubi: fn = fSub;
				isaPkg::opCmpi: fn = fCmp;
				default: fn = fBad;
			endcase
			if (fn == fAdd || fn == fSub || fn == fCmp) b = {{8{w[7]}}, w[7:0]};
			if (op == isaPkg::opLui) b = {w[7:0], 8'h00};
		end
		case (fn)
			fAnd: r = a & b;
			fOr: r = a | b;
			fXor: r = a ^ b;
			fMov: r = b;
			fAdd: begin
				r = a + b;
				sa = int'($signed(a)) + int'($signed(b));
				cand[dpPkg::flagC] = (int'(a) + int'(b)) > 65535;
				cand[dpPkg::flagF] = (sa > 32767) || (sa < -32768);
			end
			fSub: begin
				r = a - b;
				sa = int'($signed(a)) - int'($signed(b));
				cand[dpPkg::flagC] = a < b; // borrow
				cand[dpPkg::flagF] = (sa > 32767) || (sa < -32768);
			end
			fCmp: begin
				cand[dpPkg::flagL] = a < b;
				cand[dpPkg::flagN] = $signed(a) < $signed(b);
			end
			fLsh, fAshu: begin
				sh = b[4] ? int'(b[4:0]) - 32 : int'(b[4:0]); // signed 5-bit amount
				if (sh >= 0) r = a << sh;
				else if (fn == fLsh) r = a >> (-sh);
				else r = $signed(a) >>> (-sh);
			end
			default: ;
		endcase
		cand[dpPkg::flagZ] = (fn == fCmp) ? (a == b) : (r == 16'h0000);
		if (fn == fAdd || fn == fSub) begin
			upd[dpPkg::flagC] = 1'b1;
			upd[dpPkg::flagF] = 1'b1;
		end
		if (fn == fCmp) begin
			upd[dpPkg::flagL] = 1'b1;
			upd[dpPkg::flagN] = 1'b1;
		end
		expValid = v && (fn != fBad) && (fn != fCmp);
		if (v && fn != fBad) mFlags = (mFlags & ~upd) | (cand & upd);
		if (expValid) begin
			mRegs[rd] = r;
			expAddr = rd;
			expData = r;
		end
	endtask

	// starts and ends on a falling edge
	task automatic runInst(input logic [15:0] w, input logic v);
		instWord = w;
		instValid = v;
		predict(w, v);
		@(posedge clk);
		@(negedge clk);
		checkEq(16'(resultValid), 16'(expValid), "resultValid");
		if (expValid) begin
			checkEq(16'(resultAddr), 16'(expAddr), "resultAddr");
			checkEq(resultData, expData, "resultData");
		end
		checkEq(16'(flags), 16'(mFlags), "flags");
	endtask

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= maxCycles) begin
			$display("timeout: run exceeded %0d cycles", maxCycles);
			$display("Test failures found");
			$fatal(1, "simulation timed out");
		end
	end

	initial begin
		rst = 1'b1;
		instValid = 1'b0;
		instWord = '0;
		mFlags = '0;
		expValid = 1'b0;
		expAddr = '0;
		expData = '0;
		for (int i = 0; i < 16; i++) begin
			mRegs[i] = '0;
		end
		repeat (16) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		checkEq(16'(resultValid), 16'h0, "resultValid after reset");
		checkEq(16'(flags), 16'h0, "flags after reset");

		// registers come out of reset at zero
		for (int r = 0; r < 16; r++) begin
			runInst({isaPkg::opRegGroup, 4'(r), isaPkg::extMov, 4'(r)}, 1'b1);
		end

		// lui into every register and movi over the odd ones
		for (int r = 0; r < 16; r++) begin
			runInst({isaPkg::opLui, 4'(r), 8'(takeBits(8))}, 1'b1);
		end
		for (int r = 1; r < 16; r += 2) begin
			runInst({isaPkg::opMovi, 4'(r), 8'(takeBits(8))}, 1'b1);
		end

		runInst({isaPkg::opRegGroup, 4'd3, isaPkg::extXor, 4'd3}, 1'b1); // zero result
		for (int i = 0; i < randCount; i++) begin
			runInst(pickForm(logicExt[2'(takeBits(2))], logicOp[2'(takeBits(2))]), 1'b1);
		end

		runInst({isaPkg::opLui, 4'd1, 8'h7f}, 1'b1);
		runInst({isaPkg::opOri, 4'd1, 8'hff}, 1'b1);
		runInst({isaPkg::opMovi, 4'd2, 8'h01}, 1'b1);
		runInst({isaPkg::opRegGroup, 4'd1, isaPkg::extAdd, 4'd2}, 1'b1); // 7fff + 1 overflows
		runInst({isaPkg::opMovi, 4'd3, 8'h00}, 1'b1);
		runInst({isaPkg::opSubi, 4'd3, 8'h01}, 1'b1); // 0 - 1 borrows
		runInst({isaPkg::opAddui, 4'd3, 8'h01}, 1'b1); // carry out and zero
		for (int i = 0; i < randCount; i++) begin
			runInst(pickForm(arithExt[2'(takeBits(2))], arithOp[2'(takeBits(2))]), 1'b1);
		end

		runInst({isaPkg::opRegGroup, 4'd4, isaPkg::extCmp, 4'd4}, 1'b1);
		for (int i = 0; i < randCount; i++) begin
			runInst(pickForm(isaPkg::extCmp, isaPkg::opCmpi), 1'b1);
		end

		// r8 shifted by 0 and -4 and 3 in a chain
		runInst({isaPkg::opMovi, 4'd5, 8'h00}, 1'b1);
		runInst({isaPkg::opMovi, 4'd6, 8'h1c}, 1'b1);
		runInst({isaPkg::opMovi, 4'd7, 8'h03}, 1'b1);
		runInst({isaPkg::opLui, 4'd8, 8'h96}, 1'b1);
		runInst({isaPkg::opShiftGroup, 4'd8, isaPkg::extAshu, 4'd6}, 1'b1);
		runInst({isaPkg::opShiftGroup, 4'd8, isaPkg::extLsh, 4'd7}, 1'b1);
		runInst({isaPkg::opShiftGroup, 4'd8, isaPkg::extLsh, 4'd5}, 1'b1);
		runInst({isaPkg::opShiftGroup, 4'd8, isaPkg::extLsh, 4'd6}, 1'b1);
		for (int i = 0; i < randCount; i++) begin
			runInst({isaPkg::opShiftGroup, 4'(takeBits(4)),
				(takeBits(1) != 16'h0) ? isaPkg::extLsh : isaPkg::extAshu,
				4'(takeBits(4))}, 1'b1);
		end

		for (int i = 0; i < 10; i++) begin
			runInst(takeBits(16), 1'b0); // idle with a noise word
		end
		for (int i = 0; i < 20; i++) begin
			runInst({badOp[3'(takeBits(3))], 12'(takeBits(12))}, 1'b1);
		end
		runInst({isaPkg::opRegGroup, 4'd2, 4'h0, 4'd5}, 1'b1);
		runInst({isaPkg::opShiftGroup, 4'd2, 4'h5, 4'd5}, 1'b1);

		// read every register back through mov r, r
		for (int r = 0; r < 16; r++) begin
			runInst({isaPkg::opRegGroup, 4'(r), isaPkg::extMov, 4'(r)}, 1'b1);
		end
		instValid = 1'b0;
		$display("All tests passed!");
		$finish;
	end

endmodule

// File: datapath_chk.sv
`timescale 1ns/1ps

module datapathChk (
	input logic                              clk,
	input logic                              rst,
	input logic                              regWrite,
	input logic [dpPkg::flagWidth-1:0]       flagMask,
	input logic                              resultValid,
	input logic [dpPkg::regAddrWidth-1:0]    resultAddr,
	input logic [dpPkg::flagWidth-1:0]       flags
);

	// output strobe is cleared by reset
	assert property (@(posedge clk) rst |=> !resultValid)
		else $error("resultValid high in the cycle after reset");

	// empty mask means nothing was accepted
	assert property (@(posedge clk) disable iff (rst) (flagMask == '0) |=> $stable(flags))
		else $error("flags changed without an accepted instruction");

	assert property (@(posedge clk) disable iff (rst) resultValid |-> $past(regWrite))
		else $error("resultValid without a register write the cycle before");

	assert property (@(posedge clk) resultValid |-> !$isunknown(resultAddr))
		else $error("resultAddr unknown while resultValid is high");

endmodule

bind writeback datapathChk uChk (
	.clk         (clk),
	.rst         (rst),
	.regWrite    (regWrite),
	.flagMask    (flagMask),
	.resultValid (resultValid),
	.resultAddr  (resultAddr),
	.flags       (flags)
);

// File: dpPkg.sv
package dpPkg;

	localparam int wordWidth    = 16;
	localparam int numRegs      = 16;
	localparam int regAddrWidth = 4;
	localparam int flagWidth    = 5;
	localparam int ctlWidth     = 4;

	// bit positions in the flags word
	localparam int flagC = 0; // carry / borrow
	localparam int flagL = 1; // unsigned below
	localparam int flagF = 2; // signed overflow
	localparam int flagZ = 3;
	localparam int flagN = 4; // signed below

	// alu control codes
	localparam logic [3:0] ctlAnd  = 4'd0;
	localparam logic [3:0] ctlOr   = 4'd1;
	localparam logic [3:0] ctlXor  = 4'd2;
	localparam logic [3:0] ctlAdd  = 4'd3;
	localparam logic [3:0] ctlAddu = 4'd4;
	localparam logic [3:0] ctlSub  = 4'd5;
	localparam logic [3:0] ctlCmp  = 4'd6;
	localparam logic [3:0] ctlMov  = 4'd7;
	localparam logic [3:0] ctlLsh  = 4'd8;
	localparam logic [3:0] ctlAshu = 4'd9;

endpackage

// File: instDecode.sv
`timescale 1ns/1ps

module instDecode (
	input  isaPkg::instWord_u                     instWord,
	input  logic                                  instValid,
	output logic [dpPkg::regAddrWidth-1:0]        rdestAddr,
	output logic [dpPkg::regAddrWidth-1:0]        rsrcAddr,
	output logic [dpPkg::ctlWidth-1:0]            aluCtl,
	output logic [dpPkg::wordWidth-1:0]           immOperand,
	output logic                                  useImm,
	output logic                                  regWrite,
	output logic [dpPkg::flagWidth-1:0]           flagMask
);

	logic [3:0] op;
	logic [7:0] imm;
	logic known; // opcode/extension pair is a real instruction
	logic [dpPkg::flagWidth-1:0] maskRaw;

	assign op = instWord.iType.op;
	assign imm = instWord.iType.imm;
	assign rdestAddr = instWord.rType.rdest; // same bits in both views
	assign rsrcAddr = instWord.rType.rsrc; // don't care for immediates

	always_comb begin
		known = 1'b1;
		useImm = 1'b0;
		aluCtl = dpPkg::ctlMov;
		case (op)
			isaPkg::opRegGroup:
				case (instWord.rType.opExt)
					isaPkg::extAnd:  aluCtl = dpPkg::ctlAnd;
					isaPkg::extOr:   aluCtl = dpPkg::ctlOr;
					isaPkg::extXor:  aluCtl = dpPkg::ctlXor;
					isaPkg::extAdd:  aluCtl = dpPkg::ctlAdd;
					isaPkg::extAddu: aluCtl = dpPkg::ctlAddu;
					isaPkg::extSub:  aluCtl = dpPkg::ctlSub;
					isaPkg::extCmp:  aluCtl = dpPkg::ctlCmp;
					isaPkg::extMov:  aluCtl = dpPkg::ctlMov;
					default:         known = 1'b0;
				endcase
			isaPkg::opShiftGroup:
				case (instWord.rType.opExt)
					isaPkg::extLsh:  aluCtl = dpPkg::ctlLsh;
					isaPkg::extAshu: aluCtl = dpPkg::ctlAshu;
					default:         known = 1'b0;
				endcase
			default: begin
				useImm = 1'b1;
				case (op)
					isaPkg::opAndi:  aluCtl = dpPkg::ctlAnd;
					isaPkg::opOri:   aluCtl = dpPkg::ctlOr;
					isaPkg::opXori:  aluCtl = dpPkg::ctlXor;
					isaPkg::opAddi:  aluCtl = dpPkg::ctlAdd;
					isaPkg::opAddui: aluCtl = dpPkg::ctlAddu;
					isaPkg::opSubi:  aluCtl = dpPkg::ctlSub;
					isaPkg::opCmpi:  aluCtl = dpPkg::ctlCmp;
					isaPkg::opMovi:  aluCtl = dpPkg::ctlMov;
					isaPkg::opLui:   aluCtl = dpPkg::ctlMov; // move of the shifted imm
					default:         known = 1'b0;
				endcase
			end
		endcase
	end

	// logic ops and movi zero-extend, lui goes to the upper byte
	always_comb begin
		case (op)
			isaPkg::opAndi,
			isaPkg::opOri,
			isaPkg::opXori,
			isaPkg::opMovi: immOperand = {8'h00, imm};
			isaPkg::opLui:  immOperand = {imm, 8'h00};
			default:        immOperand = {{8{imm[7]}}, imm};
		endcase
	end

	// every known instruction touches Z
	always_comb begin
		maskRaw = '0;
		maskRaw[dpPkg::flagZ] = 1'b1;
		case (aluCtl)
			dpPkg::ctlAdd, dpPkg::ctlAddu, dpPkg::ctlSub: begin
				maskRaw[dpPkg::flagC] = 1'b1;
				maskRaw[dpPkg::flagF] = 1'b1;
			end
			dpPkg::ctlCmp: begin
				maskRaw[dpPkg::flagL] = 1'b1;
				maskRaw[dpPkg::flagN] = 1'b1;
			end
			default: ;
		endcase
	end

	assign regWrite = instValid && known && (aluCtl != dpPkg::ctlCmp);
	assign flagMask = (instValid && known) ? maskRaw : '0;

endmodule

// File: isaPkg.sv
package isaPkg;

	// register-type view: op, rdest, opExt, rsrc
	typedef struct packed {
		logic [3:0] op;
		logic [3:0] rdest;
		logic [3:0] opExt;
		logic [3:0] rsrc;
	} rTypeInst_s;

	// immediate-type view: op, rdest, imm
	typedef struct packed {
		logic [3:0] op;
		logic [3:0] rdest;
		logic [7:0] imm;
	} iTypeInst_s;

	// one 16-bit word, decoded either way depending on op
	typedef union packed {
		rTypeInst_s rType;
		iTypeInst_s iType;
	} instWord_u;

	// opcode groups, opExt selects the operation
	localparam logic [3:0] opRegGroup   = 4'b0000;
	localparam logic [3:0] opShiftGroup = 4'b1000;

	// immediate opcodes
	localparam logic [3:0] opAndi  = 4'b0001;
	localparam logic [3:0] opOri   = 4'b0010;
	localparam logic [3:0] opXori  = 4'b0011;
	localparam logic [3:0] opAddi  = 4'b0101;
	localparam logic [3:0] opAddui = 4'b0110;
	localparam logic [3:0] opSubi  = 4'b1001;
	localparam logic [3:0] opCmpi  = 4'b1011;
	localparam logic [3:0] opMovi  = 4'b1101;
	localparam logic [3:0] opLui   = 4'b1111;

	// extensions inside opRegGroup
	localparam logic [3:0] extAnd  = 4'b0001;
	localparam logic [3:0] extOr   = 4'b0010;
	localparam logic [3:0] extXor  = 4'b0011;
	localparam logic [3:0] extAdd  = 4'b0101;
	localparam logic [3:0] extAddu = 4'b0110;
	localparam logic [3:0] extSub  = 4'b1001;
	localparam logic [3:0] extCmp  = 4'b1011;
	localparam logic [3:0] extMov  = 4'b1101;

	// extensions inside opShiftGroup
	localparam logic [3:0] extLsh  = 4'b0100;
	localparam logic [3:0] extAshu = 4'b0110;

endpackage

// File: regFile.sv
`timescale 1ns/1ps

module regFile (
	input  logic                              clk,
	input  logic                              rst,
	input  logic                              writeEn,
	input  logic [dpPkg::regAddrWidth-1:0]    writeAddr,
	input  logic [dpPkg::wordWidth-1:0]       writeData,
	input  logic [dpPkg::regAddrWidth-1:0]    readAddr1,
	input  logic [dpPkg::regAddrWidth-1:0]    readAddr2,
	output logic [dpPkg::wordWidth-1:0]       readData1,
	output logic [dpPkg::wordWidth-1:0]       readData2
);

	logic [dpPkg::wordWidth-1:0] regs [dpPkg::numRegs];

	// single write port, registers all start at zero
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < dpPkg::numRegs; i++) begin
				regs[i] <= '0;
			end
		end else if (writeEn) begin
			regs[writeAddr] <= writeData;
		end
	end

	// reads are asynchronous, new value visible the cycle after the write
	assign readData1 = regs[readAddr1];
	assign readData2 = regs[readAddr2];

endmodule

// File: tbClock.sv
`timescale 1ns/1ps

module tbClock (
	output logic clk
);

	initial clk = 1'b0;

	always #10 clk = ~clk; // 20 ns period

endmodule

// File: writeback.sv
`timescale 1ns/1ps

module writeback (
	input  logic                              clk,
	input  logic                              rst,
	input  logic                              regWrite,
	input  logic [dpPkg::regAddrWidth-1:0]    rdestAddr,
	input  logic [dpPkg::flagWidth-1:0]       flagMask,
	input  logic [dpPkg::wordWidth-1:0]       result,
	input  logic                              carry,
	input  logic                              low,
	input  logic                              overflow,
	input  logic                              negative,
	input  logic                              zero,
	output logic                              writeEn,
	output logic [dpPkg::regAddrWidth-1:0]    writeAddr,
	output logic [dpPkg::wordWidth-1:0]       writeData,
	output logic                              resultValid,
	output logic [dpPkg::regAddrWidth-1:0]    resultAddr,
	output logic [dpPkg::wordWidth-1:0]       resultData,
	output logic [dpPkg::flagWidth-1:0]       flags
);

	logic [dpPkg::flagWidth-1:0] flagCand;

	// pack the raw alu conditions into flag positions
	always_comb begin
		flagCand = '0;
		flagCand[dpPkg::flagC] = carry;
		flagCand[dpPkg::flagL] = low;
		flagCand[dpPkg::flagF] = overflow;
		flagCand[dpPkg::flagZ] = zero;
		flagCand[dpPkg::flagN] = negative;
	end

	// regWrite already carries instValid
	assign writeEn = regWrite;
	assign writeAddr = rdestAddr;
	assign writeData = result;

	always_ff @(posedge clk) begin
		if (rst) begin
			resultValid <= 1'b0;
			flags <= '0;
		end else begin
			resultValid <= regWrite;
			flags <= (flags & ~flagMask) | (flagCand & flagMask); // masked update
		end
	end

	always_ff @(posedge clk) begin
		if (regWrite) begin
			resultAddr <= rdestAddr;
			resultData <= result;
		end
	end

endmodule
